// File: lsu_subsys.f
common/lsu_pkg.sv
lsu/ls_decode.sv
lsu/store_align.sv
lsu/load_extract.sv
lsu/lsu_core.sv
rtl/data_sram.sv
rtl/lsu_top.sv
bench/tb_clock.sv
bench/lsu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the lsu testbench with Verilator and run it
# exit status is nonzero on any build error or testbench failure

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    --top-module lsu_tb -Mdir obj_dir -o lsu_sim \
    -f lsu_subsys.f &&
./obj_dir/lsu_sim || {
    echo "simulation run failed"
    exit 1
}

// File: bench/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_tb import lsu_pkg::*; ();

    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 10;
    // byte view of the whole word array
    localparam int MEM_BYTES    = MEM_WORDS * XLEN / 8;
    // add x3, x1, x2
    localparam instr_t ALU_ADD  = 32'h0020_81b3;

    wire      clk;
    wire      rst_n;
    logic     req_valid_i;
    logic     req_ready_o;
    instr_t   instr_i;
    xlen_t    rs1_i;
    xlen_t    rs2_i;
    logic     resp_valid_o;
    logic     resp_ready_i;
    ls_resp_t resp_o;

    // reference model state
    logic [7:0] mem_model [MEM_BYTES];
    xlen_t      last_load_val;
    logic       prev_is_load;
    reg_idx_t   prev_rd;

    // request list and responses still owed
    instr_t   instr_list [$];
    xlen_t    rs1_list [$];
    xlen_t    rs2_list [$];
    ls_resp_t exp_q [$];
    int       acc_q [$];
    int       lat_q [$];

    integer seed        = 32'hb4a46eb8;
    int     cycle       = 0;
    int     cycle_limit = 0;
    int     rsp_count   = 0;

    tb_clock tb_clock_i (
        .clk     (clk),
        .rst_n_o (rst_n)
    );

    lsu_top lsu_top_i (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .instr_i      (instr_i),
        .rs1_i        (rs1_i),
        .rs2_i        (rs2_i),
        .resp_valid_o (resp_valid_o),
        .resp_ready_i (resp_ready_i),
        .resp_o       (resp_o)
    );

    task automatic stop_run(string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "testbench stopped");
    endtask

    task automatic check_value(string name, xlen_t got, xlen_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    function automatic xlen_t rand64();
        return {$random(seed), $random(seed)};
    endfunction

    // rs1 field is x1 in both formats and only its value matters
    function automatic instr_t load_instr(funct3_t f3, reg_idx_t rd, logic [11:0] imm);
        return {imm, 5'd1, f3, rd, OPC_LOAD};
    endfunction

    function automatic instr_t store_instr(funct3_t f3, reg_idx_t rs2, logic [11:0] imm);
        return {imm[11:5], rs2, 5'd1, f3, imm[4:0], OPC_STORE};
    endfunction

    task automatic push_req(instr_t ins, xlen_t rs1, xlen_t rs2);
        instr_list.push_back(ins);
        rs1_list.push_back(rs1);
        rs2_list.push_back(rs2);
    endtask

    // expected response of one accepted instruction plus the model update
    function automatic ls_resp_t expected_resp(instr_t ins, xlen_t rs1, xlen_t rs2);
        ls_resp_t r;
        logic     ld;
        logic     st;
        logic     ok;
        funct3_t  f3;
        xlen_t    addr;
        xlen_t    data;
        int       size;
        int       a;
        ld   = (ins[6:0] == OPC_LOAD);
        st   = (ins[6:0] == OPC_STORE);
        f3   = ins[14:12];
        size = 1 << int'(f3[1:0]);
        if (st) begin
            addr = rs1 + {{(XLEN-12){ins[31]}}, ins[31:25], ins[11:7]};
        end else begin
            addr = rs1 + {{(XLEN-12){ins[31]}}, ins[31:20]};
        end
        // loads stop at LWU and stores at SD with sizes naturally aligned
        ok = ((ld && f3 != 3'b111) || (st && !f3[2])) && (int'(addr[2:0]) % size == 0);
        a  = int'(addr % MEM_BYTES);
        r  = '0;
        r.is_load = ld;
        if (!ok) begin
            r.err = 1'b1;
        end else if (ld) begin
            data = '0;
            for (int i = 0; i < size; i++) begin
                data[8*i +: 8] = mem_model[a + i];
            end
            // signed kinds copy the field's top bit upward
            if (!f3[2] && size < 8 && data[8*size-1]) begin
                data = data | ~((64'd1 << (8 * size)) - 64'd1);
            end
            r.rdata       = data;
            last_load_val = data;
        end else begin
            // store right after a load into its rs2 takes the load result
            data = (prev_is_load && prev_rd == ins[24:20] && ins[24:20] != 5'd0) ?
                   last_load_val : rs2;
            for (int i = 0; i < size; i++) begin
                mem_model[a + i] = data[8*i +: 8];
            end
        end
        prev_is_load = ld;
        prev_rd      = ins[11:7];
        return r;
    endfunction

    task automatic build_requests();
        logic [31:0] r;
        logic [11:0] imm;
        xlen_t       target;
        int          off;
        funct3_t     f3;
        // random contents for words 0..31
        for (int w = 0; w < 32; w++) begin
            push_req(store_instr(F3_SD, 5'd2, 12'd0), xlen_t'(w * 8), rand64());
        end
        // every store size at every aligned lane and then the whole word
        for (int f = 0; f < 4; f++) begin
            for (int o = 0; o < 8; o += (1 << f)) begin
                push_req(store_instr(funct3_t'(f), 5'd2, 12'd0), xlen_t'((8 + f) * 8 + o),
                         rand64());
                push_req(load_instr(F3_LD, 5'd3, 12'd0), xlen_t'((8 + f) * 8), '0);
            end
        end
        // all seven load kinds over mixed sign bits
        push_req(store_instr(F3_SD, 5'd2, 12'd0), xlen_t'(40 * 8), 64'hf08e_7f80_01ff_8c73);
        for (int f = 0; f < 7; f++) begin
            for (int o = 0; o < 8; o += (1 << (f % 4))) begin
                push_req(load_instr(funct3_t'(f), 5'd3, 12'd0), xlen_t'(40 * 8 + o), '0);
            end
        end
        // misaligned, bad funct3 and non-memory opcode
        push_req(load_instr(F3_LH, 5'd3, 12'd0), xlen_t'(9 * 8 + 1), '0);
        push_req(load_instr(F3_LW, 5'd3, 12'd0), xlen_t'(9 * 8 + 2), '0);
        push_req(load_instr(F3_LD, 5'd3, 12'd0), xlen_t'(9 * 8 + 4), '0);
        push_req(store_instr(F3_SH, 5'd2, 12'd0), xlen_t'(9 * 8 + 3), rand64());
        push_req(store_instr(F3_SW, 5'd2, 12'd0), xlen_t'(10 * 8 + 1), rand64());
        push_req(store_instr(F3_SD, 5'd2, 12'd0), xlen_t'(11 * 8 + 6), rand64());
        push_req(load_instr(3'b111, 5'd3, 12'd0), xlen_t'(9 * 8), '0);
        push_req(store_instr(3'b100, 5'd2, 12'd0), xlen_t'(10 * 8), rand64());
        push_req(ALU_ADD, xlen_t'(9 * 8), rand64());
        // forwarding and then x0, an ALU op and a second load that block it
        push_req(load_instr(F3_LD, 5'd5, 12'd0), xlen_t'(12 * 8), '0);
        push_req(store_instr(F3_SD, 5'd5, 12'd0), xlen_t'(13 * 8), rand64());
        push_req(load_instr(F3_LW, 5'd7, 12'd4), xlen_t'(12 * 8), '0);
        push_req(store_instr(F3_SH, 5'd7, 12'd2), xlen_t'(14 * 8), rand64());
        push_req(load_instr(F3_LD, 5'd0, 12'd0), xlen_t'(12 * 8), '0);
        push_req(store_instr(F3_SD, 5'd0, 12'd0), xlen_t'(15 * 8), rand64());
        push_req(load_instr(F3_LD, 5'd6, 12'd0), xlen_t'(12 * 8), '0);
        push_req(ALU_ADD, '0, '0);
        push_req(store_instr(F3_SD, 5'd6, 12'd0), xlen_t'(16 * 8), rand64());
        push_req(load_instr(F3_LD, 5'd5, 12'd0), xlen_t'(12 * 8), '0);
        push_req(load_instr(F3_LD, 5'd9, 12'd0), xlen_t'(11 * 8), '0);
        push_req(store_instr(F3_SD, 5'd5, 12'd0), xlen_t'(17 * 8), rand64());
        // read back everything touched above
        for (int w = 9; w < 18; w++) begin
            push_req(load_instr(F3_LD, 5'd3, 12'd0), xlen_t'(w * 8), '0);
        end
        // negative offsets where the last one wraps to the top word
        push_req(store_instr(F3_SD, 5'd2, 12'hf00), 64'h400, rand64());
        push_req(load_instr(F3_LB, 5'd3, 12'hff3), 64'h310, '0);
        push_req(load_instr(F3_LW, 5'd3, 12'h800), 64'hb04, '0);
        push_req(store_instr(F3_SW, 5'd2, 12'hffc), 64'd0, rand64());
        push_req(load_instr(F3_LD, 5'd3, 12'h000), 64'h7f8, '0);
        // random mix over words 0..31 with rd and rs2 in x0..x7
        for (int n = 0; n < 60; n++) begin
            r   = $random(seed);
            imm = r[17:6];
            off = int'(r[5:3]);
            // one in four keeps the raw offset
            if (r[27:26] != 2'b00) begin
                off = off - (off % (1 << int'(r[1:0])));
            end
            target = xlen_t'(int'(r[22:18]) * 8 + off) - {{(XLEN-12){imm[11]}}, imm};
            f3     = (r[28] && r[27:26] != 2'b00) ? {1'b0, r[1:0]} : r[2:0];
            if (r[31:29] == 3'b111) begin
                push_req(ALU_ADD, target, rand64());
            end else if (r[28]) begin
                push_req(store_instr(f3, reg_idx_t'(r[25:23]), imm), target, rand64());
            end else begin
                push_req(load_instr(f3, reg_idx_t'(r[25:23]), imm), target, '0);
            end
        end
    endtask

    initial begin : stimulus
        ls_resp_t e;
        req_valid_i = 1'b0;
        instr_i     = '0;
        rs1_i       = '0;
        rs2_i       = '0;
        // cleared like the sram
        for (int b = 0; b < MEM_BYTES; b++) begin
            mem_model[b] = 8'h00;
        end
        last_load_val = '0;
        prev_is_load  = 1'b0;
        prev_rd       = '0;
        build_requests();
        cycle_limit = 10 * instr_list.size() + RESET_CYCLES;
        wait (rst_n === 1'b1);
        @(negedge clk);
        check_value("req_ready_o", xlen_t'(req_ready_o), 64'd1);
        check_value("resp_valid_o", xlen_t'(resp_valid_o), 64'd0);
        @(posedge clk);
        #DRIVE_DELAY;
        foreach (instr_list[i]) begin
            req_valid_i = 1'b1;
            instr_i     = instr_list[i];
            rs1_i       = rs1_list[i];
            rs2_i       = rs2_list[i];
            // ready seen here means a handshake on the next edge
            @(negedge clk);
            while (!req_ready_o) begin
                @(negedge clk);
            end
            e = expected_resp(instr_list[i], rs1_list[i], rs2_list[i]);
            exp_q.push_back(e);
            acc_q.push_back(cycle);
            lat_q.push_back(e.err ? 1 : MEM_LAT + 2);
            @(posedge clk);
            #DRIVE_DELAY;
        end
        req_valid_i = 1'b0;
        while (rsp_count < instr_list.size()) begin
            @(posedge clk);
        end
        // a repeated response would show up within a few idle cycles
        repeat (4) @(negedge clk);
        if (!resp_valid_o && req_ready_o) begin
            $display("sim passed");
            $finish;
        end else begin
            stop_run("response repeated after the last handshake");
        end
    end

    // random low stretches of 1 to 4 cycles on resp_ready_i
    initial begin : ready_drive
        int          hold_cnt;
        logic [31:0] r;
        hold_cnt     = 0;
        resp_ready_i = 1'b0;
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (hold_cnt > 0) begin
                hold_cnt--;
                resp_ready_i = 1'b0;
            end else begin
                r = $random(seed);
                if (r[2:0] == 3'b000) begin
                    hold_cnt     = int'(r[4:3]);
                    resp_ready_i = 1'b0;
                end else begin
                    resp_ready_i = 1'b1;
                end
            end
        end
    end

    initial begin : compare
        ls_resp_t exp;
        ls_resp_t held;
        logic     holding;
        logic     seen;
        logic     done_last;
        holding   = 1'b0;
        seen      = 1'b0;
        done_last = 1'b0;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge clk);
            if (resp_valid_o && req_ready_o) begin
                stop_run("request port ready while a response waits");
            end
            // request port reopens in the cycle after a response handshake
            if (done_last) begin
                check_value("req_ready_o", xlen_t'(req_ready_o), 64'd1);
            end
            done_last = 1'b0;
            // payload must not move while it waits for ready
            if (holding) begin
                if (!resp_valid_o) begin
                    stop_run("response withdrawn before its handshake");
                end
                check_value("held resp_o.rdata", resp_o.rdata, held.rdata);
                check_value("held resp_o.err", xlen_t'(resp_o.err), xlen_t'(held.err));
                check_value("held resp_o.is_load", xlen_t'(resp_o.is_load),
                            xlen_t'(held.is_load));
            end
            // latency check on the first cycle of a response
            if (resp_valid_o && !seen) begin
                if (exp_q.size() == 0) begin
                    stop_run("response without an outstanding request");
                end
                seen = 1'b1;
                check_value("response latency", xlen_t'(cycle - acc_q[0]), xlen_t'(lat_q[0]));
            end
            if (resp_valid_o && resp_ready_i) begin
                exp = exp_q.pop_front();
                void'(acc_q.pop_front());
                void'(lat_q.pop_front());
                check_value("resp_o.rdata", resp_o.rdata, exp.rdata);
                check_value("resp_o.err", xlen_t'(resp_o.err), xlen_t'(exp.err));
                check_value("resp_o.is_load", xlen_t'(resp_o.is_load), xlen_t'(exp.is_load));
                rsp_count++;
                seen      = 1'b0;
                holding   = 1'b0;
                done_last = 1'b1;
            end else begin
                holding = resp_valid_o;
                held    = resp_o;
            end
        end
    end

    // run length bound
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle_limit > 0 && cycle > cycle_limit) begin
            stop_run($sformatf("timeout after %0d cycles", cycle));
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n_o
);

    // 40 ns period
    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // release shortly after the tenth rising edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// File: rtl/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top import lsu_pkg::*; (
    input  wire         clk,
    input  wire         rst_n_i,
    input  wire         req_valid_i,
    output logic        req_ready_o,
    input  wire instr_t instr_i,
    input  wire xlen_t  rs1_i,
    input  wire xlen_t  rs2_i,
    output logic        resp_valid_o,
    input  wire         resp_ready_i,
    output ls_resp_t    resp_o
);

    ls_op_t   op;
    mem_req_t mem_req;
    logic     mem_ack;
    xlen_t    mem_rdata;
    xlen_t    last_load_data;
    // request handshake
    logic     accept;

    assign accept = req_valid_i && req_ready_o;

    ls_decode ls_decode_i (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .instr_i          (instr_i),
        .rs1_i            (rs1_i),
        .rs2_i            (rs2_i),
        .accept_i         (accept),
        .last_load_data_i (last_load_data),
        .op_o             (op)
    );

    lsu_core lsu_core_i (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .req_valid_i      (req_valid_i),
        .req_ready_o      (req_ready_o),
        .op_i             (op),
        .mem_o            (mem_req),
        .mem_ack_i        (mem_ack),
        .mem_rdata_i      (mem_rdata),
        .resp_valid_o     (resp_valid_o),
        .resp_ready_i     (resp_ready_i),
        .resp_o           (resp_o),
        .last_load_data_o (last_load_data)
    );

    data_sram data_sram_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .mem_i   (mem_req),
        .ack_o   (mem_ack),
        .rdata_o (mem_rdata)
    );

endmodule

`default_nettype wire

// File: rtl/data_sram.sv
`timescale 1ns/1ps
`default_nettype none

module data_sram import lsu_pkg::*; (
    input  wire           clk,
    input  wire           rst_n_i,
    input  wire mem_req_t mem_i,
    output logic          ack_o,
    output xlen_t         rdata_o
);

    xlen_t                mem_q [MEM_WORDS];
    logic [LAT_CNT_W-1:0] wait_q;
    logic                 en;
    // last wait cycle where the access happens
    logic                 fire;

    // memory comes up cleared
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_q[i] = '0;
        end
    end

    assign en   = mem_i.rd_en || mem_i.wr_en;
    assign fire = en && !ack_o && (wait_q == LAT_CNT_W'(MEM_LAT - 1));

    // count cycles of a held enable
    // the enable is still high in the ack cycle and that one is skipped
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wait_q <= '0;
            ack_o  <= 1'b0;
        end else begin
            ack_o <= fire;
            if (en && !ack_o && !fire) begin
                wait_q <= wait_q + 1'b1;
            end else begin
                wait_q <= '0;
            end
        end
    end

    // byte-masked write once per access
    always_ff @(posedge clk) begin
        if (fire && mem_i.wr_en) begin
            for (int b = 0; b < XLEN / 8; b++) begin
                if (mem_i.wmask[b]) begin
                    mem_q[mem_i.waddr][8*b +: 8] <= mem_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // read word lines up with ack
    always_ff @(posedge clk) begin
        if (fire && mem_i.rd_en) begin
            rdata_o <= mem_q[mem_i.waddr];
        end
    end

    // word index stays put while the access waits
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (en && !ack_o) |=> (en && $stable(mem_i.waddr)));

endmodule

`default_nettype wire

// File: lsu/lsu_core.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_core import lsu_pkg::*; (
    input  wire         clk,
    input  wire         rst_n_i,
    input  wire         req_valid_i,
    output logic        req_ready_o,
    input  wire ls_op_t op_i,
    output mem_req_t    mem_o,
    input  wire         mem_ack_i,
    input  wire xlen_t  mem_rdata_i,
    output logic        resp_valid_o,
    input  wire         resp_ready_i,
    output ls_resp_t    resp_o,
    output xlen_t       last_load_data_o
);

    ls_state_e state_q;
    ls_state_e state_d;
    ls_op_t    op_q;
    ls_resp_t  resp_q;
    xlen_t     last_load_q;
    logic      accept;
    logic      aligned;
    logic      f3_legal;
    logic      op_ok;
    logic      mem_en;
    xlen_t     load_data;

    assign accept = req_valid_i && req_ready_o;

    // natural alignment, size is funct3[1:0] for loads and stores
    always_comb begin
        case (op_i.funct3[1:0])
            2'b00:   aligned = 1'b1;
            2'b01:   aligned = (op_i.addr[0] == 1'b0);
            2'b10:   aligned = (op_i.addr[1:0] == 2'b00);
            default: aligned = (op_i.addr[OFF_W-1:0] == '0);
        endcase
    end

    // 3'b111 is no load, and stores stop at doubleword
    assign f3_legal = op_i.is_load ? (op_i.funct3 != 3'b111) : !op_i.funct3[2];
    assign op_ok    = (op_i.is_load || op_i.is_store) && f3_legal && aligned;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                // bad requests go straight to an error response
                if (accept) begin
                    state_d = op_ok ? ACCESS : RESP;
                end
            end
            ACCESS: begin
                if (mem_ack_i) begin
                    state_d = RESP;
                end
            end
            RESP: begin
                if (resp_ready_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // operation held for the whole access
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q <= op_i;
        end
    end

    store_align store_align_i (
        .funct3_i  (op_q.funct3),
        .addr_lo_i (op_q.addr[OFF_W-1:0]),
        .wdata_i   (op_q.wdata),
        .wmask_o   (mem_o.wmask),
        .wdata_o   (mem_o.wdata)
    );

    load_extract load_extract_i (
        .funct3_i  (op_q.funct3),
        .addr_lo_i (op_q.addr[OFF_W-1:0]),
        .word_i    (mem_rdata_i),
        .data_o    (load_data)
    );

    assign mem_o.rd_en = (state_q == ACCESS) && op_q.is_load;
    assign mem_o.wr_en = (state_q == ACCESS) && op_q.is_store;
    assign mem_o.waddr = op_q.addr[OFF_W +: WADDR_W];
    assign mem_en      = mem_o.rd_en || mem_o.wr_en;

    // response loads once and then holds through RESP
    always_ff @(posedge clk) begin
        if (accept && !op_ok) begin
            resp_q.rdata   <= '0;
            resp_q.err     <= 1'b1;
            resp_q.is_load <= op_i.is_load;
        end else if ((state_q == ACCESS) && mem_ack_i) begin
            resp_q.rdata   <= op_q.is_load ? load_data : '0;
            resp_q.err     <= 1'b0;
            resp_q.is_load <= op_q.is_load;
        end
    end

    // source of store data forwarding
    always_ff @(posedge clk) begin
        if ((state_q == ACCESS) && mem_ack_i && op_q.is_load) begin
            last_load_q <= load_data;
        end
    end

    assign req_ready_o      = (state_q == IDLE);
    assign resp_valid_o     = (state_q == RESP);
    assign resp_o           = resp_q;
    assign last_load_data_o = last_load_q;

    // one access is either a read or a write
    assert property (@(posedge clk) disable iff (!rst_n_i)
        !(mem_o.rd_en && mem_o.wr_en));

    // memory has no ready, request must hold until ack
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (mem_en && !mem_ack_i) |=> (mem_en && $stable(mem_o)));

    // held response keeps its payload
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (resp_valid_o && !resp_ready_i) |=> (resp_valid_o && $stable(resp_o)));

endmodule

`default_nettype wire

// File: lsu/load_extract.sv
`timescale 1ns/1ps
`default_nettype none

module load_extract import lsu_pkg::*; (
    input  wire funct3_t          funct3_i,
    input  wire logic [OFF_W-1:0] addr_lo_i,
    input  wire xlen_t            word_i,
    output xlen_t                 data_o
);

    // addressed byte moved down to lane 0
    xlen_t shifted;

    assign shifted = word_i >> {addr_lo_i, 3'b000};

    always_comb begin
        case (funct3_i)
            // signed kinds copy the top bit of the field
            F3_LB: begin
                data_o = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
            end
            F3_LH: begin
                data_o = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
            end
            F3_LW: begin
                data_o = {{(XLEN-32){shifted[31]}}, shifted[31:0]};
            end
            F3_LD: begin
                data_o = shifted;
            end
            // unsigned kinds fill with zeros
            F3_LBU: begin
                data_o = {{(XLEN-8){1'b0}}, shifted[7:0]};
            end
            F3_LHU: begin
                data_o = {{(XLEN-16){1'b0}}, shifted[15:0]};
            end
            F3_LWU: begin
                data_o = {{(XLEN-32){1'b0}}, shifted[31:0]};
            end
            default: begin
                data_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: lsu/store_align.sv
`timescale 1ns/1ps
`default_nettype none

module store_align import lsu_pkg::*; (
    input  wire funct3_t          funct3_i,
    input  wire logic [OFF_W-1:0] addr_lo_i,
    input  wire xlen_t            wdata_i,
    output be_t                   wmask_o,
    output xlen_t                 wdata_o
);

    // contiguous enables for the access size, before the shift
    be_t base_mask;

    always_comb begin
        case (funct3_i)
            F3_SB: begin
                base_mask = be_t'(8'h01);
                // one byte copied into every lane
                wdata_o   = {8{wdata_i[7:0]}};
            end
            F3_SH: begin
                base_mask = be_t'(8'h03);
                wdata_o   = {4{wdata_i[15:0]}};
            end
            F3_SW: begin
                base_mask = be_t'(8'h0f);
                wdata_o   = {2{wdata_i[31:0]}};
            end
            F3_SD: begin
                base_mask = be_t'(8'hff);
                wdata_o   = wdata_i;
            end
            default: begin
                // no such store size, nothing gets written
                base_mask = '0;
                wdata_o   = '0;
            end
        endcase
    end

    // move the enables up to the addressed lanes
    // aligned offsets keep them inside the word
    assign wmask_o = be_t'(base_mask << addr_lo_i);

endmodule

`default_nettype wire

// File: lsu/ls_decode.sv
`timescale 1ns/1ps
`default_nettype none

module ls_decode import lsu_pkg::*; (
    input  wire         clk,
    input  wire         rst_n_i,
    input  wire instr_t instr_i,
    input  wire xlen_t  rs1_i,
    input  wire xlen_t  rs2_i,
    input  wire         accept_i,
    input  wire xlen_t  last_load_data_i,
    output ls_op_t      op_o
);

    logic [6:0] opcode;
    funct3_t    funct3;
    reg_idx_t   rd_field;
    reg_idx_t   rs2_field;
    logic       is_load;
    logic       is_store;
    xlen_t      imm_i;
    xlen_t      imm_s;
    // previous accepted instruction
    logic       prev_load_q;
    reg_idx_t   prev_rd_q;
    logic       fwd;

    // fixed instruction fields
    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    assign rd_field  = instr_i[11:7];
    assign rs2_field = instr_i[24:20];

    assign is_load  = (opcode == OPC_LOAD);
    assign is_store = (opcode == OPC_STORE);

    // I-type and S-type offsets, both sign-extended from bit 31
    assign imm_i = {{(XLEN-12){instr_i[ILEN-1]}}, instr_i[31:20]};
    assign imm_s = {{(XLEN-12){instr_i[ILEN-1]}}, instr_i[31:25], instr_i[11:7]};

    // remember kind and rd of each accepted instruction
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prev_load_q <= 1'b0;
            prev_rd_q   <= '0;
        end else if (accept_i) begin
            prev_load_q <= is_load;
            prev_rd_q   <= rd_field;
        end
    end

    // store right after a load into its rs2, x0 never forwards
    assign fwd = is_store && prev_load_q && (prev_rd_q == rs2_field) && (rs2_field != '0);

    always_comb begin
        op_o.is_load  = is_load;
        op_o.is_store = is_store;
        op_o.funct3   = funct3;
        op_o.addr     = rs1_i + (is_store ? imm_s : imm_i);
        op_o.wdata    = fwd ? last_load_data_i : rs2_i;
        // stores carry immediate bits where rd sits
        op_o.rd       = is_load ? rd_field : '0;
    end

endmodule

`default_nettype wire

// File: common/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // core widths
    localparam int XLEN      = 64;
    localparam int ILEN      = 32;

    // data memory geometry
    localparam int MEM_WORDS = 256;
    localparam int WADDR_W   = $clog2(MEM_WORDS);
    // wait cycles from first enable to acknowledge
    localparam int MEM_LAT   = 2;
    localparam int LAT_CNT_W = $clog2(MEM_LAT + 1);
    // byte offset bits inside one memory word
    localparam int OFF_W     = $clog2(XLEN / 8);

    // plain vectors with a meaning
    typedef logic [XLEN-1:0]    xlen_t;
    typedef logic [ILEN-1:0]    instr_t;
    typedef logic [2:0]         funct3_t;
    typedef logic [XLEN/8-1:0]  be_t;
    typedef logic [4:0]         reg_idx_t;
    typedef logic [WADDR_W-1:0] word_addr_t;

    // major opcodes of the memory instructions
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    // load kinds
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LD  = 3'b011;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;
    localparam funct3_t F3_LWU = 3'b110;

    // store kinds
    localparam funct3_t F3_SB  = 3'b000;
    localparam funct3_t F3_SH  = 3'b001;
    localparam funct3_t F3_SW  = 3'b010;
    localparam funct3_t F3_SD  = 3'b011;

    // load/store core states
    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        RESP
    } ls_state_e;

    // one decoded memory operation
    typedef struct packed {
        logic     is_load;
        logic     is_store;
        funct3_t  funct3;
        xlen_t    addr;
        xlen_t    wdata;
        reg_idx_t rd;
    } ls_op_t;

    // response back to the requester
    typedef struct packed {
        xlen_t rdata;
        logic  err;
        logic  is_load;
    } ls_resp_t;

    // core to data memory
    typedef struct packed {
        logic       rd_en;
        logic       wr_en;
        word_addr_t waddr;
        xlen_t      wdata;
        be_t        wmask;
    } mem_req_t;

endpackage

`default_nettype wire
